/* rtl/softmax_pkg.sv */
package softmax_pkg;

    localparam int unsigned ELEM_W   = 8;
    localparam int unsigned EXP_W    = 16;
    localparam int unsigned EXP_FRAC = 15;
    localparam int unsigned ACC_W    = 24;

    // Bits needed to index the leading one of the denominator
    localparam int unsigned POS_W    = $clog2(ACC_W);

    typedef logic [ELEM_W-1:0] elem_t;
    typedef logic [EXP_W-1:0]  exp_t;
    typedef logic [ACC_W-1:0]  acc_t;
    typedef logic [ELEM_W-1:0] shift_t;

    // 1.0 in Q1.15
    localparam exp_t EXP_ONE = exp_t'(1) << EXP_FRAC;

    typedef struct packed {
        logic clear;
        logic normalize;
    } softmax_cmd_t;

    typedef struct packed {
        logic upd_max;
        logic exp_en;
        logic acc_en;
        logic norm_en;
        logic clear;
    } stage_ctrl_t;

    typedef struct packed {
        logic  busy;
        elem_t max;
        acc_t  denom;
    } softmax_flags_t;

endpackage

/* rtl/softmax_ctrl.sv */
`timescale 1ns/1ps

module softmax_ctrl import softmax_pkg::*; (
    input  logic         clk_i,
    input  logic         rst_ni,
    input  softmax_cmd_t cmd_i,
    input  logic         in_valid_i,
    output stage_ctrl_t  stage_o,
    output logic         busy_o,
    output logic         out_valid_o
);

    // Bit n belongs to the vector sitting in stage n+1
    logic [2:0] valid_q;
    logic [2:0] pass_q;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
            pass_q  <= '0;
        end else begin
            valid_q <= {valid_q[1:0], in_valid_i};
            pass_q  <= {pass_q[1:0], cmd_i.normalize};
        end
    end

    // Max only moves for accumulate-pass vectors
    assign stage_o.upd_max = in_valid_i & ~cmd_i.normalize;
    assign stage_o.exp_en  = valid_q[0];

    // Third stage is picked by the pass the vector entered with
    assign stage_o.acc_en  = valid_q[1] & ~pass_q[1];
    assign stage_o.norm_en = valid_q[1] & pass_q[1];
    assign stage_o.clear   = cmd_i.clear;

    assign out_valid_o = valid_q[2] & pass_q[2];
    assign busy_o      = |valid_q;

    // A vector next to a clear would be lost or mixed into stale state
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        cmd_i.clear |-> !in_valid_i)
    else $error("softmax_ctrl: in_valid_i together with clear");

    // Vectors still in flight would see max and denom vanish under them
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        cmd_i.clear |-> !busy_o)
    else $error("softmax_ctrl: clear while pipeline busy");

endmodule

/* rtl/max_tracker.sv */
`timescale 1ns/1ps

module max_tracker import softmax_pkg::*; #(
    parameter int unsigned N_LANES = 4
) (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  stage_ctrl_t               stage_i,
    input  elem_t [N_LANES-1:0]       in_vect_i,
    output elem_t [N_LANES-1:0]       vect_o,
    output elem_t                     max_o,
    output shift_t                    delta_o
);

    elem_t lane_max;
    elem_t new_max;

    always_comb begin
        lane_max = '0;
        for (int i = 0; i < N_LANES; i++) begin
            if (in_vect_i[i] > lane_max) begin
                lane_max = in_vect_i[i];
            end
        end
    end

    assign new_max = (lane_max > max_o) ? lane_max : max_o;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            max_o   <= '0;
            delta_o <= '0;
        end else if (stage_i.clear) begin
            max_o   <= '0;
            delta_o <= '0;
        end else if (stage_i.upd_max) begin
            max_o   <= new_max;
            delta_o <= shift_t'(new_max - max_o);
        end else begin
            // Frozen max in the normalise pass, so no rescale
            delta_o <= '0;
        end
    end

    always_ff @(posedge clk_i) begin
        vect_o <= in_vect_i;
    end

endmodule

/* rtl/exp2_unit.sv */
`timescale 1ns/1ps

module exp2_unit import softmax_pkg::*; #(
    parameter int unsigned N_LANES = 4
) (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  stage_ctrl_t         stage_i,
    input  elem_t [N_LANES-1:0] vect_i,
    input  elem_t               max_i,
    input  shift_t              delta_i,
    output exp_t  [N_LANES-1:0] exp_o,
    output shift_t              delta_o
);

    shift_t [N_LANES-1:0] diff;
    exp_t   [N_LANES-1:0] weight;
    logic                 lanes_ok;

    always_comb begin
        lanes_ok = 1'b1;
        for (int i = 0; i < N_LANES; i++) begin
            diff[i] = max_i - vect_i[i];
            // 2^-(max - x), saturating to zero past the LSB
            weight[i] = (diff[i] >= EXP_W) ? '0 : (EXP_ONE >> diff[i]);
            if (vect_i[i] > max_i) begin
                lanes_ok = 1'b0;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (stage_i.exp_en) begin
            exp_o <= weight;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            delta_o <= '0;
        end else begin
            delta_o <= delta_i;
        end
    end

    // Tracker max must already cover every lane it is applied to
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        stage_i.exp_en |-> lanes_ok)
    else $error("exp2_unit: lane above running max");

endmodule

/* rtl/denom_acc.sv */
`timescale 1ns/1ps

module denom_acc import softmax_pkg::*; #(
    parameter int unsigned N_LANES = 4
) (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  stage_ctrl_t        stage_i,
    input  exp_t [N_LANES-1:0] exp_i,
    input  shift_t             delta_i,
    output acc_t               denom_o
);

    localparam int unsigned LEVELS = $clog2(N_LANES);
    localparam int unsigned LEAVES = 1 << LEVELS;

    acc_t tree [LEVELS+1][LEAVES];
    acc_t lane_sum;

    // Pairwise adder tree, unused leaves padded with zero
    always_comb begin
        tree = '{default: '0};
        for (int i = 0; i < N_LANES; i++) begin
            tree[0][i] = acc_t'(exp_i[i]);
        end
        for (int l = 0; l < LEVELS; l++) begin
            for (int i = 0; i < (LEAVES >> (l + 1)); i++) begin
                tree[l+1][i] = tree[l][2*i] + tree[l][2*i+1];
            end
        end
    end

    assign lane_sum = tree[LEVELS][0];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            denom_o <= '0;
        end else if (stage_i.clear) begin
            denom_o <= '0;
        end else if (stage_i.acc_en) begin
            // Old terms rescaled to the new max before adding
            denom_o <= (denom_o >> delta_i) + lane_sum;
        end
    end

endmodule

/* rtl/normalizer.sv */
`timescale 1ns/1ps

module normalizer import softmax_pkg::*; #(
    parameter int unsigned N_LANES = 4
) (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  stage_ctrl_t        stage_i,
    input  exp_t [N_LANES-1:0] exp_i,
    input  acc_t               denom_i,
    output exp_t [N_LANES-1:0] out_vect_o
);

    logic [POS_W-1:0] lead_pos;
    shift_t           norm_shift;

    // Highest set bit wins
    always_comb begin
        lead_pos = '0;
        for (int b = 0; b < ACC_W; b++) begin
            if (denom_i[b]) begin
                lead_pos = POS_W'(b);
            end
        end
    end

    // Divide by 2^p, then scale back up by 2^15 so 1.0 stays in Q1.15
    assign norm_shift = (lead_pos > EXP_FRAC) ? shift_t'(lead_pos - EXP_FRAC) : '0;

    always_ff @(posedge clk_i) begin
        if (stage_i.norm_en) begin
            for (int i = 0; i < N_LANES; i++) begin
                out_vect_o[i] <= exp_i[i] >> norm_shift;
            end
        end
    end

    // Normalise pass needs a finished accumulate pass before it
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        stage_i.norm_en |-> denom_i != '0)
    else $error("normalizer: zero denominator");

endmodule

/* rtl/softmax_top.sv */
`timescale 1ns/1ps

module softmax_top import softmax_pkg::*; #(
    parameter int unsigned N_LANES = 4
) (
    input  logic                clk_i,
    input  logic                rst_ni,
    input  softmax_cmd_t        cmd_i,
    input  logic                in_valid_i,
    input  elem_t [N_LANES-1:0] in_vect_i,
    output logic                out_valid_o,
    output exp_t  [N_LANES-1:0] out_vect_o,
    output softmax_flags_t      flags_o
);

    stage_ctrl_t          stage;
    logic                 busy;
    elem_t [N_LANES-1:0]  trk_vect;
    elem_t                cur_max;
    shift_t               trk_delta;
    exp_t  [N_LANES-1:0]  weights;
    shift_t               exp_delta;
    acc_t                 denom;

    softmax_ctrl i_ctrl (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .cmd_i       (cmd_i),
        .in_valid_i  (in_valid_i),
        .stage_o     (stage),
        .busy_o      (busy),
        .out_valid_o (out_valid_o)
    );

    max_tracker #(.N_LANES(N_LANES)) i_max (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .stage_i   (stage),
        .in_vect_i (in_vect_i),
        .vect_o    (trk_vect),
        .max_o     (cur_max),
        .delta_o   (trk_delta)
    );

    exp2_unit #(.N_LANES(N_LANES)) i_exp (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .stage_i (stage),
        .vect_i  (trk_vect),
        .max_i   (cur_max),
        .delta_i (trk_delta),
        .exp_o   (weights),
        .delta_o (exp_delta)
    );

    denom_acc #(.N_LANES(N_LANES)) i_acc (
        .clk_i   (clk_i),
        .rst_ni  (rst_ni),
        .stage_i (stage),
        .exp_i   (weights),
        .delta_i (exp_delta),
        .denom_o (denom)
    );

    normalizer #(.N_LANES(N_LANES)) i_norm (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .stage_i    (stage),
        .exp_i      (weights),
        .denom_i    (denom),
        .out_vect_o (out_vect_o)
    );

    assign flags_o.busy  = busy;
    assign flags_o.max   = cur_max;
    assign flags_o.denom = denom;

endmodule

/* sim/tb_softmax_model.svh */
`ifndef TB_SOFTMAX_MODEL_SVH
`define TB_SOFTMAX_MODEL_SVH

// Common 32-bit LCG constants
function automatic logic [31:0] lcg_next(input logic [31:0] state);
    return state * 32'd1664525 + 32'd1013904223;
endfunction

// 2^-(m - x) in Q1.15, zero once the shift reaches 16
function automatic exp_t exp_weight(input elem_t m, input elem_t x);
    int d;
    d = int'(m) - int'(x);
    if (d >= 16) begin
        return '0;
    end
    return exp_t'(32'h8000 >> d);
endfunction

function automatic int lead_one(input acc_t d);
    for (int b = ACC_W - 1; b >= 0; b--) begin
        if (d[b]) begin
            return b;
        end
    end
    return 0;
endfunction

// Division by the denominator approximated by its leading one
function automatic exp_t norm_lane(input exp_t w, input acc_t d);
    int p;
    p = lead_one(d);
    if (p <= int'(EXP_FRAC)) begin
        return w;
    end
    return w >> (p - int'(EXP_FRAC));
endfunction

`endif

/* sim/tb_softmax.sv */
`timescale 1ns/1ps

module tb_softmax import softmax_pkg::*; ();

    localparam int unsigned N_LANES = 4;

    typedef elem_t [N_LANES-1:0] vect_t;
    typedef exp_t  [N_LANES-1:0] out_t;

    typedef struct packed {
        softmax_cmd_t cmd;
        logic         valid;
        vect_t        vect;
    } entry_t;

    `include "tb_softmax_model.svh"

    logic           clk_i = 1'b0;
    logic           rst_ni;
    softmax_cmd_t   cmd_i;
    logic           in_valid_i;
    vect_t          in_vect_i;
    logic           out_valid_o;
    out_t           out_vect_o;
    softmax_flags_t flags_o;

    entry_t      tbl[$];
    out_t        exp_q[$];
    acc_t        denom_at[int];
    logic [31:0] lcg_state = 32'h9f33;
    logic        tbl_ready = 1'b0;
    elem_t       m_model;
    acc_t        d_model;
    acc_t        denom_exp;
    int          n_checks;
    int          n_errors;

    softmax_top #(.N_LANES(N_LANES)) dut (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .cmd_i       (cmd_i),
        .in_valid_i  (in_valid_i),
        .in_vect_i   (in_vect_i),
        .out_valid_o (out_valid_o),
        .out_vect_o  (out_vect_o),
        .flags_o     (flags_o)
    );

    always #10 clk_i = ~clk_i;

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
        n_checks++;
        if (got !== expected) begin
            n_errors++;
            $display("[ERROR] %0t %s: got %0h, expected %0h", $time, name, got, expected);
        end
    endtask

    task automatic add_entry(input logic clear, input logic norm, input logic valid,
                             input vect_t v);
        tbl.push_back(entry_t'({clear, norm, valid, v}));
    endtask

    task automatic add_rand(input logic norm, input int base, input int span, input int count);
        vect_t v;
        repeat (count) begin
            for (int i = 0; i < N_LANES; i++) begin
                lcg_state = lcg_next(lcg_state);
                v[i] = elem_t'(base + int'(lcg_state[30:16]) % span);
            end
            add_entry(1'b0, norm, 1'b1, v);
        end
    endtask

    // Outputs seen after edge c, before entry c is driven
    task automatic check_outputs(input int c);
        out_t want;
        logic busy_exp;
        logic ov_exp;
        busy_exp = 1'b0;
        for (int j = 1; j <= 3; j++) begin
            busy_exp |= (c >= j) && tbl[c-j].valid;
        end
        ov_exp = (c >= 3) && tbl[c-3].valid && tbl[c-3].cmd.normalize;
        if (denom_at.exists(c)) begin
            denom_exp = denom_at[c];
        end
        check_val("flags_o.busy", flags_o.busy, busy_exp);
        check_val("flags_o.max", flags_o.max, m_model);
        check_val("flags_o.denom", flags_o.denom, denom_exp);
        check_val("out_valid_o", out_valid_o, ov_exp);
        if (out_valid_o === 1'b1) begin
            if (exp_q.size() == 0) begin
                n_errors++;
                $display("Output valid at %0t but no output was expected", $time);
            end else begin
                want = exp_q.pop_front();
                for (int i = 0; i < N_LANES; i++) begin
                    check_val($sformatf("out_vect_o[%0d]", i), out_vect_o[i], want[i]);
                end
            end
        end
    endtask

    task automatic model_step(input int c, input entry_t e);
        elem_t  new_max;
        shift_t delta;
        acc_t   sum;
        out_t   o;
        if (e.cmd.clear) begin
            m_model = '0;
            d_model = '0;
            denom_at[c+1] = '0;
        end else if (e.valid && !e.cmd.normalize) begin
            new_max = m_model;
            sum = '0;
            for (int i = 0; i < N_LANES; i++) begin
                new_max = (e.vect[i] > new_max) ? e.vect[i] : new_max;
            end
            for (int i = 0; i < N_LANES; i++) begin
                sum += acc_t'(exp_weight(new_max, e.vect[i]));
            end
            delta = new_max - m_model;
            d_model = (d_model >> delta) + sum;
            m_model = new_max;
            denom_at[c+3] = d_model;
        end else if (e.valid) begin
            for (int i = 0; i < N_LANES; i++) begin
                o[i] = norm_lane(exp_weight(m_model, e.vect[i]), d_model);
            end
            exp_q.push_back(o);
        end
    endtask

    initial begin
        n_checks = 0;
        n_errors = 0;
        rst_ni = 1'b0;
        cmd_i = '0;
        in_valid_i = 1'b0;
        in_vect_i = '0;
        m_model = '0;
        d_model = '0;
        denom_exp = '0;

        // Ascending max, lane 3 first in each literal
        add_entry(1'b0, 1'b0, 1'b1, {8'd1, 8'd7, 8'd3, 8'd10});
        add_entry(1'b0, 1'b0, 1'b1, {8'd0, 8'd5, 8'd12, 8'd12});
        add_entry(1'b0, 1'b0, 1'b1, {8'd8, 8'd19, 8'd2, 8'd20});
        add_entry(1'b0, 1'b0, 1'b1, {8'd40, 8'd35, 8'd24, 8'd40});
        repeat (3) add_entry(1'b0, 1'b0, 1'b0, '0);
        // Normalise pass, lanes 24 and 0 sit 16 or more below the max
        add_entry(1'b0, 1'b1, 1'b1, {8'd20, 8'd38, 8'd39, 8'd40});
        add_entry(1'b0, 1'b1, 1'b1, {8'd0, 8'd24, 8'd40, 8'd30});
        repeat (4) add_entry(1'b0, 1'b0, 1'b0, '0);
        // Back to back, switching pass while vectors are in flight
        add_rand(1'b0, 192, 64, 6);
        add_entry(1'b0, 1'b0, 1'b1, {8'd239, 8'd240, 8'd250, 8'd255});
        add_rand(1'b1, 200, 56, 6);
        add_rand(1'b0, 192, 64, 2);
        repeat (4) add_entry(1'b0, 1'b0, 1'b0, '0);
        // Clear on an idle pipeline, then a fresh pass
        add_entry(1'b1, 1'b0, 1'b0, '0);
        add_entry(1'b0, 1'b0, 1'b0, '0);
        add_entry(1'b0, 1'b0, 1'b1, {8'd9, 8'd2, 8'd9, 8'd5});
        add_entry(1'b0, 1'b0, 1'b1, {8'd59, 8'd45, 8'd50, 8'd60});
        add_entry(1'b0, 1'b1, 1'b1, {8'd0, 8'd59, 8'd44, 8'd60});
        repeat (5) add_entry(1'b0, 1'b0, 1'b0, '0);
        tbl_ready = 1'b1;

        repeat (16) @(posedge clk_i);
        #2 rst_ni = 1'b1;
        for (int c = 0; c < tbl.size(); c++) begin
            @(posedge clk_i);
            #2;
            check_outputs(c);
            cmd_i = tbl[c].cmd;
            in_valid_i = tbl[c].valid;
            in_vect_i = tbl[c].vect;
            model_step(c, tbl[c]);
        end
        if (exp_q.size() != 0) begin
            n_errors++;
            $display("%0d expected output vectors never appeared", exp_q.size());
        end
        $display("Checks: %0d, errors: %0d", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

    initial begin
        wait (tbl_ready);
        #((tbl.size() + 50) * 20);
        $display("Timeout: the stimulus table did not complete in time");
        $display("TB FAILED");
        $finish;
    end

endmodule

/* all.f */
+incdir+sim
rtl/softmax_pkg.sv
rtl/softmax_ctrl.sv
rtl/max_tracker.sv
rtl/exp2_unit.sv
rtl/denom_acc.sv
rtl/normalizer.sv
rtl/softmax_top.sv
sim/tb_softmax.sv

/* Bender.yml */
package:
  name: softmax_fixed

sources:
  - files:
      - rtl/softmax_pkg.sv
      - rtl/softmax_ctrl.sv
      - rtl/max_tracker.sv
      - rtl/exp2_unit.sv
      - rtl/denom_acc.sv
      - rtl/normalizer.sv
      - rtl/softmax_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/tb_softmax.sv
